// ==== rtl/vid_pkg.sv ====
package vid_pkg;

    // Host register offsets
    localparam logic [7:0] ADDR_CTRL    = 8'h00;
    localparam logic [7:0] ADDR_H1      = 8'h28;
    localparam logic [7:0] ADDR_H2      = 8'h30;
    localparam logic [7:0] ADDR_V1      = 8'h38;
    localparam logic [7:0] ADDR_V2      = 8'h40;
    localparam logic [7:0] ADDR_BASE    = 8'h48;
    localparam logic [7:0] ADDR_LINEINC = 8'h50;

    localparam int TIMING_W = 13;               // Timing fields and counters
    localparam int PCNT_W   = 6;                // Pixel clock divider
    localparam int PIXEL_W  = 24;               // R 23:16, G 15:8, B 7:0

    // Control register layout
    typedef struct packed {
        logic [21:0]       unused_hi;
        logic [PCNT_W-1:0] pcnt;                // Bits 9:4
        logic              en;                  // Bit 3
        logic [2:0]        unused_lo;
    } ctrl_view_t;

    // H1, H2, V1 and V2 all carry two 13-bit fields
    typedef struct packed {
        logic [5:0]          unused_hi;
        logic [TIMING_W-1:0] first;             // Bits 25:13
        logic [TIMING_W-1:0] second;            // Bits 12:0
    } pair_view_t;

    // One host write word, decoded per offset
    typedef union packed {
        ctrl_view_t ctrl;
        pair_view_t pair;
    } reg_word_t;

endpackage

// ==== rtl/vid_regs.sv ====
`timescale 1ns/10ps

module vid_regs
    import vid_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                reg_wr,
    input  logic [7:0]          reg_addr,
    input  logic [31:0]         reg_wdata,
    output logic                enable,
    output logic [PCNT_W-1:0]   pcnt,
    output logic [TIMING_W-1:0] hsize,
    output logic [TIMING_W-1:0] hend,
    output logic [TIMING_W-1:0] hsync_start,
    output logic [TIMING_W-1:0] hsync_end,
    output logic [TIMING_W-1:0] vsize,
    output logic [TIMING_W-1:0] vend,
    output logic [TIMING_W-1:0] vsync_start,
    output logic [TIMING_W-1:0] vsync_end,
    output logic [31:0]         base_addr,
    output logic [31:0]         line_inc
);

    reg_word_t wr_word;

    assign wr_word = reg_wdata;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable      <= 1'b0;
            pcnt        <= '0;
            hsize       <= '0;
            hend        <= '0;
            hsync_start <= '0;
            hsync_end   <= '0;
            vsize       <= '0;
            vend        <= '0;
            vsync_start <= '0;
            vsync_end   <= '0;
            base_addr   <= '0;
            line_inc    <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                ADDR_CTRL: begin
                    enable <= wr_word.ctrl.en;
                    pcnt   <= wr_word.ctrl.pcnt;
                end
                ADDR_H1: begin
                    hsize <= wr_word.pair.first;
                    hend  <= wr_word.pair.second;
                end
                ADDR_H2: begin
                    hsync_start <= wr_word.pair.first;
                    hsync_end   <= wr_word.pair.second;
                end
                ADDR_V1: begin
                    vsize <= wr_word.pair.first;
                    vend  <= wr_word.pair.second;
                end
                ADDR_V2: begin
                    vsync_start <= wr_word.pair.first;
                    vsync_end   <= wr_word.pair.second;
                end
                ADDR_BASE:    base_addr <= reg_wdata;
                ADDR_LINEINC: line_inc  <= reg_wdata;
                default: ;                      // Unmapped offsets dropped
            endcase
        end
    end

    // Visible area has to fit inside the total raster while running
    assert property (@(posedge clk) disable iff (!reset_n)
        enable |-> (hsize < hend) && (vsize < vend))
        else $error("vid_regs: visible size not below total size");

endmodule

// ==== rtl/vid_timing.sv ====
`timescale 1ns/10ps

module vid_timing
    import vid_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable,
    input  logic [PCNT_W-1:0]   pcnt,
    input  logic [TIMING_W-1:0] hsize,
    input  logic [TIMING_W-1:0] hend,
    input  logic [TIMING_W-1:0] hsync_start,
    input  logic [TIMING_W-1:0] hsync_end,
    input  logic [TIMING_W-1:0] vsize,
    input  logic [TIMING_W-1:0] vend,
    input  logic [TIMING_W-1:0] vsync_start,
    input  logic [TIMING_W-1:0] vsync_end,
    output logic                hsync,
    output logic                hblank,
    output logic                vsync,
    output logic                vblank,
    output logic                pix_pop,
    output logic                blank_next
);

    logic [PCNT_W-1:0]   pdiv;
    logic [TIMING_W-1:0] h_cnt;                 // Position shown on the next tick
    logic [TIMING_W-1:0] v_cnt;
    logic [TIMING_W-1:0] h_inc;
    logic [TIMING_W-1:0] v_inc;
    logic                running;               // Low in the first enabled cycle
    logic                tick;
    logic                h_wrap;
    logic                v_wrap;
    logic                h_vis;
    logic                v_vis;

    assign tick   = running && enable && (pdiv >= pcnt);
    assign h_inc  = h_cnt + 1'b1;
    assign v_inc  = v_cnt + 1'b1;
    assign h_wrap = h_inc >= hend;
    assign v_wrap = v_inc >= vend;
    assign h_vis  = h_cnt < hsize;
    assign v_vis  = v_cnt < vsize;

    assign pix_pop    = tick && h_vis && v_vis;
    assign blank_next = tick ? !(h_vis && v_vis) : (hblank || vblank);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            running <= 1'b0;
            pdiv    <= '0;
        end else begin
            running <= enable;
            if (!running || !enable || tick) begin
                pdiv <= '0;
            end else begin
                pdiv <= pdiv + 1'b1;
            end
        end
    end

    // A new frame starts in vertical blanking, which gives the fetch
    // engine time to fill the FIFO before line 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!enable) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!running) begin
            h_cnt <= '0;
            v_cnt <= vsize;                     // First blank line
        end else if (tick) begin
            if (h_wrap) begin
                h_cnt <= '0;
                v_cnt <= v_wrap ? '0 : v_inc;
            end else begin
                h_cnt <= h_inc;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            vsync  <= 1'b0;
            vblank <= 1'b1;
        end else if (!enable) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            vsync  <= 1'b0;
            vblank <= 1'b1;
        end else if (tick) begin
            hsync  <= (h_cnt >= hsync_start) && (h_cnt < hsync_end);
            hblank <= !h_vis;
            vsync  <= (v_cnt >= vsync_start) && (v_cnt < vsync_end);
            vblank <= !v_vis;
        end
    end

endmodule

// ==== rtl/pixel_fetch.sv ====
`timescale 1ns/10ps

module pixel_fetch
    import vid_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int BURST_LEN  = 4
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       enable,
    input  logic [TIMING_W-1:0]        hsize,
    input  logic [TIMING_W-1:0]        vsize,
    input  logic [31:0]                base_addr,
    input  logic [31:0]                line_inc,
    input  logic                       pix_taken,
    output logic                       rd_req,
    output logic [31:0]                rd_addr,
    output logic [$clog2(BURST_LEN):0] rd_len
);

    localparam int CRED_W = $clog2(FIFO_DEPTH) + 1;
    localparam int LEN_W  = $clog2(BURST_LEN) + 1;

    logic [CRED_W-1:0]   credits;               // One per free FIFO entry
    logic [TIMING_W-1:0] x_cnt;                 // Word index within the line
    logic [TIMING_W-1:0] y_cnt;
    logic [TIMING_W-1:0] x_next;
    logic [31:0]         line_base;
    logic                issue;
    logic                line_done;
    logic                frame_done;

    assign issue      = enable && (credits >= CRED_W'(BURST_LEN));
    assign x_next     = x_cnt + TIMING_W'(BURST_LEN);
    assign line_done  = x_next >= hsize;
    assign frame_done = (y_cnt + 1'b1) >= vsize;
    assign rd_len     = LEN_W'(BURST_LEN);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CRED_W'(FIFO_DEPTH);
        end else if (!enable) begin
            credits <= CRED_W'(FIFO_DEPTH);
        end else begin
            credits <= credits - (issue ? CRED_W'(BURST_LEN) : '0) + CRED_W'(pix_taken);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_req    <= 1'b0;
            rd_addr   <= '0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            line_base <= '0;
        end else if (!enable) begin
            rd_req    <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            line_base <= base_addr;             // Frame restarts at the base
        end else begin
            rd_req <= issue;
            if (issue) begin
                rd_addr <= line_base + 32'({x_cnt, 2'b00});
                if (line_done) begin
                    x_cnt <= '0;
                    if (frame_done) begin
                        y_cnt     <= '0;
                        line_base <= base_addr;
                    end else begin
                        y_cnt     <= y_cnt + 1'b1;
                        line_base <= line_base + line_inc;
                    end
                end else begin
                    x_cnt <= x_next;
                end
            end
        end
    end

    // Returned credits can never outnumber the FIFO entries
    assert property (@(posedge clk) disable iff (!reset_n)
        credits <= CRED_W'(FIFO_DEPTH))
        else $error("pixel_fetch: credit count above FIFO depth");

endmodule

// ==== rtl/pixel_scanout.sv ====
`timescale 1ns/10ps

module pixel_scanout
    import vid_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable,
    input  logic        rd_valid,
    input  logic [31:0] rd_data,
    input  logic        pix_pop,
    input  logic        blank_next,
    output logic        pix_taken,
    output logic [7:0]  R,
    output logic [7:0]  G,
    output logic [7:0]  B
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [PIXEL_W-1:0] fifo_mem [FIFO_DEPTH];
    logic [AW:0]        wr_ptr;                 // Extra bit tells full from empty
    logic [AW:0]        rd_ptr;
    logic [PIXEL_W-1:0] rgb;
    logic               push;
    logic               pop;
    logic               empty;
    logic               full;

    assign push      = enable && rd_valid;
    assign empty     = wr_ptr == rd_ptr;
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop       = pix_pop && !empty;
    assign pix_taken = pop;

    assign R = rgb[23:16];
    assign G = rgb[15:8];
    assign B = rgb[7:0];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr[AW-1:0]] <= rd_data[PIXEL_W-1:0];   // Top byte dropped
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rgb    <= '0;
        end else if (!enable) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rgb    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                rgb    <= fifo_mem[rd_ptr[AW-1:0]];
            end else if (blank_next) begin
                rgb <= '0;                      // Black outside the visible area
            end
        end
    end

    // Credit scheme upstream should keep room for every returned word
    assert property (@(posedge clk) disable iff (!reset_n) push |-> !full)
        else $error("pixel_scanout: push while FIFO full");

    // Display reached a visible pixel before its data arrived
    assert property (@(posedge clk) disable iff (!reset_n) pix_pop |-> !empty)
        else $error("pixel_scanout: FIFO underrun");

endmodule

// ==== rtl/vid_top.sv ====
`timescale 1ns/10ps

module vid_top
    import vid_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,              // Power of two, multiple of BURST_LEN
    parameter int BURST_LEN  = 4
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       reg_wr,
    input  logic [7:0]                 reg_addr,
    input  logic [31:0]                reg_wdata,
    output logic                       rd_req,
    output logic [31:0]                rd_addr,
    output logic [$clog2(BURST_LEN):0] rd_len,
    input  logic                       rd_valid,
    input  logic [31:0]                rd_data,
    output logic                       hsync,
    output logic                       hblank,
    output logic                       vsync,
    output logic                       vblank,
    output logic [7:0]                 R,
    output logic [7:0]                 G,
    output logic [7:0]                 B
);

    logic                enable;
    logic [PCNT_W-1:0]   pcnt;
    logic [TIMING_W-1:0] hsize;
    logic [TIMING_W-1:0] hend;
    logic [TIMING_W-1:0] hsync_start;
    logic [TIMING_W-1:0] hsync_end;
    logic [TIMING_W-1:0] vsize;
    logic [TIMING_W-1:0] vend;
    logic [TIMING_W-1:0] vsync_start;
    logic [TIMING_W-1:0] vsync_end;
    logic [31:0]         base_addr;
    logic [31:0]         line_inc;
    logic                pix_pop;
    logic                blank_next;
    logic                pix_taken;             // Returns one fetch credit

    vid_regs regs0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .enable      (enable),
        .pcnt        (pcnt),
        .hsize       (hsize),
        .hend        (hend),
        .hsync_start (hsync_start),
        .hsync_end   (hsync_end),
        .vsize       (vsize),
        .vend        (vend),
        .vsync_start (vsync_start),
        .vsync_end   (vsync_end),
        .base_addr   (base_addr),
        .line_inc    (line_inc)
    );

    vid_timing timing0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable      (enable),
        .pcnt        (pcnt),
        .hsize       (hsize),
        .hend        (hend),
        .hsync_start (hsync_start),
        .hsync_end   (hsync_end),
        .vsize       (vsize),
        .vend        (vend),
        .vsync_start (vsync_start),
        .vsync_end   (vsync_end),
        .hsync       (hsync),
        .hblank      (hblank),
        .vsync       (vsync),
        .vblank      (vblank),
        .pix_pop     (pix_pop),
        .blank_next  (blank_next)
    );

    pixel_fetch #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .BURST_LEN  (BURST_LEN)
    ) fetch0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable    (enable),
        .hsize     (hsize),
        .vsize     (vsize),
        .base_addr (base_addr),
        .line_inc  (line_inc),
        .pix_taken (pix_taken),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_len    (rd_len)
    );

    pixel_scanout #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) scanout0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable     (enable),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .pix_pop    (pix_pop),
        .blank_next (blank_next),
        .pix_taken  (pix_taken),
        .R          (R),
        .G          (G),
        .B          (B)
    );

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/10ps

module mem_model #(
    parameter int LEN_W = 3
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             rd_req,
    input  logic [31:0]      rd_addr,
    input  logic [LEN_W-1:0] rd_len,
    output logic             rd_valid,
    output logic [31:0]      rd_data,
    output logic             idle
);

    localparam logic [31:0] SEED = 32'h5e9aa6a0;

    logic [31:0] addr_q [$];                    // Outstanding bursts in request order
    int          len_q [$];
    logic [31:0] lfsr;
    logic [31:0] cur_addr;
    logic        busy;
    int          wait_cnt;
    int          words_left;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk) begin : serve
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] s3;
        if (!reset_n) begin
            addr_q.delete();
            len_q.delete();
            lfsr     <= SEED;
            busy      = 1'b0;
            wait_cnt  = 0;
            rd_valid <= 1'b0;
            rd_data  <= '0;
            idle     <= 1'b1;
        end else begin
            if (rd_req) begin
                addr_q.push_back(rd_addr);
                len_q.push_back(int'(rd_len));
            end
            rd_valid <= 1'b0;
            if (!busy) begin
                if (addr_q.size() > 0) begin
                    s1 = lfsr_step(lfsr);
                    s2 = lfsr_step(s1);
                    s3 = lfsr_step(s2);
                    wait_cnt   = int'({s1[0], s2[0], s3[0]});   // 0 to 7 cycles
                    lfsr      <= s3;
                    cur_addr   = addr_q.pop_front();
                    words_left = len_q.pop_front();
                    busy       = 1'b1;
                end
            end else if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                rd_valid  <= 1'b1;
                rd_data   <= {8'h00, cur_addr[23:0] ^ 24'ha5c3f0};
                cur_addr   = cur_addr + 32'd4;
                words_left = words_left - 1;
                if (words_left == 0) begin
                    busy = 1'b0;
                end
            end
            idle <= !busy && (addr_q.size() == 0);
        end
    end

endmodule

// ==== tests/tb_vid_top.sv ====
`timescale 1ns/10ps

module tb_vid_top
    import vid_pkg::*;
();

    localparam int FIFO_DEPTH = 16;
    localparam int BURST_LEN  = 4;
    localparam int LEN_W      = $clog2(BURST_LEN) + 1;
    localparam int HSIZE = 8, HEND = 16, HS_START = 10, HS_END = 13;
    localparam int VSIZE = 4, VEND = 6, VS_START = 4, VS_END = 5;
    localparam logic [31:0] BASE = 32'h1000;
    localparam logic [31:0] LINE_INC = 32'h40;
    localparam int SETUP_CLKS = 300;
    localparam int WATCHDOG_CLKS = 3 * HEND * VEND * 2 * 2 + 3 * HEND * VEND * 1 * 2 + SETUP_CLKS;

    logic clk = 1'b0;
    logic reset_n, reg_wr, rd_req, rd_valid, mem_idle;
    logic [7:0] reg_addr, R, G, B;
    logic [31:0] reg_wdata, rd_addr, rd_data;
    logic [LEN_W-1:0] rd_len;
    logic hsync, hblank, vsync, vblank;

    logic en_tb, idle_chk, hb_q, vb_q, line_ok, frame_seen;
    int cur_pcnt, pclk, hlow_run, line_clk, cur_line, frames, req_words, shown;
    int y_now, pred_line, x_now, outstanding;
    logic hb_fall, vb_fall, new_pixel;
    logic [23:0] exp_rgb;

    always #10 clk = !clk;

    vid_top #(.FIFO_DEPTH(FIFO_DEPTH), .BURST_LEN(BURST_LEN)) dut0 (
        .clk(clk), .reset_n(reset_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .rd_req(rd_req), .rd_addr(rd_addr), .rd_len(rd_len),
        .rd_valid(rd_valid), .rd_data(rd_data), .hsync(hsync), .hblank(hblank),
        .vsync(vsync), .vblank(vblank), .R(R), .G(G), .B(B)
    );

    mem_model #(.LEN_W(LEN_W)) mem0 (
        .clk(clk), .reset_n(reset_n), .rd_req(rd_req), .rd_addr(rd_addr), .rd_len(rd_len),
        .rd_valid(rd_valid), .rd_data(rd_data), .idle(mem_idle)
    );

    // Frame buffer word at pixel (x, y) as the memory returns it
    function automatic logic [23:0] pixel_at(input int x, input int y);
        logic [31:0] addr;
        addr = BASE + LINE_INC * y + 32'(4 * x);
        return addr[23:0] ^ 24'ha5c3f0;
    endfunction

    function automatic logic [31:0] pair_word(input int first, input int second);
        return {6'd0, 13'(first), 13'(second)};
    endfunction

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    assign pclk        = cur_pcnt + 1;
    assign hb_fall     = en_tb && hb_q && !hblank;
    assign vb_fall     = en_tb && vb_q && !vblank;
    assign y_now       = vb_fall ? 0 : (hb_fall ? cur_line + 1 : cur_line);
    assign pred_line   = (cur_line + 1 >= VEND) ? 0 : cur_line + 1;
    assign x_now       = hlow_run / pclk;
    assign new_pixel   = !hblank && !vblank && (hlow_run % pclk == 0);
    assign exp_rgb     = pixel_at(x_now, y_now);
    assign outstanding = req_words - shown;        // Words fetched but not yet shown

    always @(posedge clk) begin
        hb_q <= hblank;
        vb_q <= vblank;
        if (!en_tb) begin
            hlow_run   <= 0;
            line_clk   <= 0;
            line_ok    <= 1'b0;
            cur_line   <= 0;
            frame_seen <= 1'b0;
            req_words  <= 0;
            shown      <= 0;
        end else begin
            hlow_run <= hblank ? 0 : hlow_run + 1;
            line_clk <= hb_fall ? 1 : line_clk + 1;
            line_ok  <= line_ok || hb_fall;
            cur_line <= y_now;
            if (vb_fall) begin
                frame_seen <= 1'b1;
                frames     <= frames + 1;
            end
            if (rd_req) req_words <= req_words + BURST_LEN;
            if (new_pixel) shown <= shown + 1;
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!idle_chk)
        !hsync && !vsync && hblank && vblank && {R, G, B} == 24'h0 && !rd_req)
        else begin
            $display("Outputs left the reset state while disabled");
            report_failure();
        end
    a_hlow: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        $rose(hblank) |-> hlow_run == HSIZE * pclk)
        else begin
            $display("MISMATCH hblank_low_clocks got %h expected %h",
                     $sampled(hlow_run), HSIZE * pclk);
            report_failure();
        end
    a_line: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        hb_fall && line_ok |-> line_clk == HEND * pclk)
        else begin
            $display("MISMATCH line_clocks got %h expected %h", $sampled(line_clk), HEND * pclk);
            report_failure();
        end
    a_hsync: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        line_ok |-> hsync == (line_clk >= HS_START * pclk && line_clk < HS_END * pclk))
        else begin
            $display("MISMATCH hsync got %h expected %h", $sampled(hsync),
                     $sampled(line_clk) >= HS_START * pclk &&
                     $sampled(line_clk) < HS_END * pclk);
            report_failure();
        end
    a_vblank: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        frame_seen && hb_fall |-> vblank == (pred_line >= VSIZE))
        else begin
            $display("MISMATCH vblank got %h expected %h", $sampled(vblank),
                     $sampled(pred_line) >= VSIZE);
            report_failure();
        end
    a_vsync: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        frame_seen && hb_fall |-> vsync == (pred_line >= VS_START && pred_line < VS_END))
        else begin
            $display("MISMATCH vsync got %h expected %h", $sampled(vsync),
                     $sampled(pred_line) >= VS_START && $sampled(pred_line) < VS_END);
            report_failure();
        end
    a_vstable: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        frame_seen && !hb_fall |-> $stable(vblank) && $stable(vsync))
        else begin
            $display("vblank or vsync changed in the middle of a line");
            report_failure();
        end
    a_pixel: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        (frame_seen || vb_fall) && !hblank && !vblank |-> {R, G, B} == exp_rgb)
        else begin
            $display("MISMATCH RGB got %h expected %h", $sampled({R, G, B}), $sampled(exp_rgb));
            report_failure();
        end
    a_black: assert property (@(posedge clk) disable iff (!reset_n)
        hblank || vblank |-> {R, G, B} == 24'h0)
        else begin
            $display("MISMATCH RGB_blank got %h expected %h", $sampled({R, G, B}), 24'h0);
            report_failure();
        end
    a_len: assert property (@(posedge clk) disable iff (!reset_n)
        rd_req |-> rd_len == LEN_W'(BURST_LEN))
        else begin
            $display("MISMATCH rd_len got %h expected %h", $sampled(rd_len), BURST_LEN);
            report_failure();
        end
    a_depth: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        outstanding <= FIFO_DEPTH)
        else begin
            $display("MISMATCH outstanding got %h limit %h", $sampled(outstanding), FIFO_DEPTH);
            report_failure();
        end
    a_credit: assert property (@(posedge clk) disable iff (!reset_n || !en_tb)
        rd_req |-> outstanding <= FIFO_DEPTH - BURST_LEN)
        else begin
            $display("MISMATCH outstanding_at_req got %h limit %h", $sampled(outstanding),
                     FIFO_DEPTH - BURST_LEN);
            report_failure();
        end

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // Enables the display and runs until three frame starts are seen
    task automatic run_display(input int p);
        int start;
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= ADDR_CTRL;
        reg_wdata <= {22'd0, 6'(p), 1'b1, 3'd0};
        en_tb     <= 1'b1;
        idle_chk  <= 1'b0;
        cur_pcnt  <= p;
        @(posedge clk);
        reg_wr <= 1'b0;
        start = frames;
        while (frames < start + 3) @(posedge clk);
    endtask

    task automatic stop_display(input int p);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= ADDR_CTRL;
        reg_wdata <= {22'd0, 6'(p), 1'b0, 3'd0};
        en_tb     <= 1'b0;
        @(posedge clk);
        reg_wr <= 1'b0;
        repeat (p + 1) @(posedge clk);
        idle_chk <= 1'b1;
        while (!mem_idle) @(posedge clk);      // Let stale bursts drain
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        report_failure();
    end

    initial begin
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reset_n   = 1'b0;
        en_tb     = 1'b0;
        idle_chk  = 1'b0;
        cur_pcnt  = 1;
        frames    = 0;
        @(posedge clk);
        idle_chk <= 1'b1;
        repeat (7) @(posedge clk);
        reset_n <= 1'b1;
        write_reg(ADDR_H1, pair_word(HSIZE, HEND));
        write_reg(ADDR_H2, pair_word(HS_START, HS_END));
        write_reg(ADDR_V1, pair_word(VSIZE, VEND));
        write_reg(ADDR_V2, pair_word(VS_START, VS_END));
        write_reg(ADDR_BASE, BASE);
        write_reg(ADDR_LINEINC, LINE_INC);
        run_display(1);
        stop_display(1);
        run_display(0);                        // Restart must begin at the base again
        stop_display(0);
        repeat (4) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/vid_pkg.sv
rtl/vid_regs.sv
rtl/vid_timing.sv
rtl/pixel_fetch.sv
rtl/pixel_scanout.sv
rtl/vid_top.sv
tests/mem_model.sv
tests/tb_vid_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_vid_top -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$output" | grep -qx "Simulation completed successfully" || exit 1
exit 0
